/* Bender.yml */
package:
  name: int_pipe

sources:
  # packages first, then the design bottom up
  - rtl/isa_pkg.sv
  - rtl/pipe_pkg.sv
  - rtl/reg_file.sv
  - rtl/decode_stage.sv
  - rtl/id_ex_reg.sv
  - rtl/forward_unit.sv
  - rtl/alu.sv
  - rtl/execute_stage.sv
  - rtl/int_pipe_top.sv
  - target: test
    files:
      - dv/clk_gen.sv
      - dv/tb_int_pipe.sv

/* dv/clk_gen.sv */
module clk_gen #(
    parameter int PERIOD       = 8,    // ns
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* dv/tb_int_pipe.sv */
module tb_int_pipe;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 8;
    localparam int PROG_LEN   = 200;
    localparam int DRAIN      = 4;     // idle issues that flush the last results out

    logic                            clk;
    logic                            rst_n;
    logic                            instr_valid;
    logic [isa_pkg::XLEN-1:0]        instr;
    logic [isa_pkg::XLEN-1:0]        pc;
    logic                            wb_en;
    logic [isa_pkg::REG_ADDR_W-1:0]  wb_rd;
    logic [isa_pkg::XLEN-1:0]        wb_data;
    pipe_pkg::ex_mem_t               ex_mem;

    integer            seed      = 32'h15ae4544;
    int                errors    = 0;
    int                issued    = 0;
    int                flushed   = 0;
    logic              kill_next = 1'b0;   // last issued instruction was a taken BEQ
    logic [4:0]        load_rd   = '0;     // rd of a LW issued one cycle ago
    logic [31:0]       model_regs [0:31];
    logic [31:0]       model_mem [logic [31:0]];
    logic [31:0]       dmem [logic [31:0]];   // memory seen by the MEM stage
    pipe_pkg::ex_mem_t expected_q [$];
    pipe_pkg::ex_mem_t exp_cur = '0;        // record due in ex_mem this cycle

    clk_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(10)) i_clk_gen (.clk(clk), .rst_n(rst_n));

    int_pipe_top i_int_pipe_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .ex_mem      (ex_mem)
    );

    // initial data memory contents, every address bit matters
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:0] ^ addr[31:16], ~addr[15:0]} ^ 32'h6c8e_9cf5;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        errors++;
        $display("CHECK FAILED %s got %h expected %h at %0t", name, got, want, $time);
    endtask

    // builds one instruction, runs it on the model and queues its ex_mem record
    task automatic issue_next(input int idx, input logic live);
        logic [31:0]       r;
        logic [31:0]       s;
        logic [31:0]       a;
        logic [31:0]       b;
        logic [31:0]       imm;
        logic [31:0]       res;
        logic [31:0]       word;
        logic [31:0]       pc_val;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        logic [4:0]        rd;
        logic [2:0]        f3;
        logic              sub;
        logic              killed;
        int                kind;
        pipe_pkg::ex_mem_t exp;
        r      = $random(seed);
        s      = $random(seed);
        kind   = live ? int'(r[31:16] % 10) : -1;
        pc_val = 32'h1000 + (idx << 2);
        killed = live && kill_next;
        rs1    = {2'b00, r[2:0]};   // x0..x7 keeps dependencies dense
        rs2    = {2'b00, r[5:3]};
        rd     = {2'b00, r[8:6]};
        if (kind == 6 && s[0]) rs2 = rs1;   // more taken branches
        if (rs1 == load_rd) rs1 = '0;       // no load-use pairs
        if (rs2 == load_rd) rs2 = '0;
        a         = model_regs[rs1];
        b         = model_regs[rs2];
        imm       = {{20{s[31]}}, s[31:20]};
        exp       = '0;
        exp.valid = 1'b1;
        exp.rd    = rd;
        case (kind)
            0, 1, 2: begin   // R-type
                sub = (s[2:0] == 3'd1);
                case (s[2:0])
                    3'd0, 3'd1: f3 = 3'b000;
                    3'd2, 3'd6: f3 = 3'b010;
                    3'd3:       f3 = 3'b100;
                    3'd4:       f3 = 3'b110;
                    default:    f3 = 3'b111;
                endcase
                case (f3)
                    3'b000:  res = sub ? a - b : a + b;
                    3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b100:  res = a ^ b;
                    3'b110:  res = a | b;
                    default: res = a & b;
                endcase
                word          = {1'b0, sub, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
                exp.reg_write = 1'b1;
                exp.alu_data  = res;
            end
            3: begin   // ADDI
                word          = {s[31:20], rs1, 3'b000, rd, 7'b0010011};
                res           = a + imm;
                exp.reg_write = 1'b1;
                exp.alu_data  = res;
            end
            4: begin   // LW
                word          = {s[31:20], rs1, 3'b010, rd, 7'b0000011};
                exp.reg_write = 1'b1;
                exp.mem_read  = 1'b1;
                exp.alu_data  = a + imm;
                res = model_mem.exists(a + imm) ? model_mem[a + imm] : fill_word(a + imm);
            end
            5: begin   // SW
                word            = {s[31:25], rs2, rs1, 3'b010, s[24:20], 7'b0100011};
                exp.mem_write   = 1'b1;
                exp.alu_data    = a + imm;
                exp.memory_data = b;
            end
            6: begin   // BEQ
                imm               = {{19{s[31]}}, s[31:20], 1'b0};
                word = {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
                exp.branch_taken  = (a == b);
                exp.branch_target = pc_val + imm;
            end
            7: begin   // JAL
                imm           = {{11{s[31]}}, s[31:12], 1'b0};
                word          = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
                res           = pc_val + 32'd4;
                exp.reg_write = 1'b1;
                exp.alu_data  = res;
            end
            8: begin   // JALR
                word          = {s[31:20], rs1, 3'b000, rd, 7'b1100111};
                res           = pc_val + 32'd4;
                exp.reg_write = 1'b1;
                exp.alu_data  = res;
            end
            default: begin
                word = {s[31:12], rd, 7'b0110111};   // LUI, outside the subset
                exp  = '0;
            end
        endcase
        kill_next = 1'b0;
        if (!live || killed) begin
            exp = '0;
        end else begin
            if (exp.reg_write && rd != '0) model_regs[rd] = res;   // x0 stays zero
            if (exp.mem_write) model_mem[exp.alu_data] = exp.memory_data;
            kill_next = exp.branch_taken;
        end
        load_rd     = (kind == 4) ? rd : '0;
        instr_valid = live;
        instr       = word;
        pc          = pc_val;
        expected_q.push_back(exp);
        if (live) issued++;
        if (killed) flushed++;
    endtask

    // MEM/WB emulation, one register stage between ex_mem and the writeback port
    initial begin
        logic        pend_en;
        logic [4:0]  pend_rd;
        logic [31:0] pend_data;
        logic [31:0] addr;
        wb_en   = 1'b0;
        wb_rd   = '0;
        wb_data = '0;
        pend_en = 1'b0;
        forever begin
            @(negedge clk);
            wb_en     = pend_en;
            wb_rd     = pend_rd;
            wb_data   = pend_data;
            addr      = ex_mem.alu_data;
            pend_en   = ex_mem.valid && ex_mem.reg_write;
            pend_rd   = ex_mem.rd;
            pend_data = ex_mem.alu_data;
            if (ex_mem.valid && ex_mem.mem_write) dmem[addr] = ex_mem.memory_data;
            if (ex_mem.valid && ex_mem.mem_read) begin
                pend_data = dmem.exists(addr) ? dmem[addr] : fill_word(addr);
            end
        end
    end

    // a record issued on one falling edge shows in ex_mem two rising edges later
    always @(posedge clk) begin
        if (expected_q.size() == 2) exp_cur <= expected_q.pop_front();
    end

    assert property (@(negedge clk) ex_mem.valid === exp_cur.valid)
        else report_mismatch("ex_mem.valid", ex_mem.valid, exp_cur.valid);
    assert property (@(negedge clk) ex_mem.reg_write === exp_cur.reg_write)
        else report_mismatch("ex_mem.reg_write", ex_mem.reg_write, exp_cur.reg_write);
    assert property (@(negedge clk) ex_mem.mem_read === exp_cur.mem_read)
        else report_mismatch("ex_mem.mem_read", ex_mem.mem_read, exp_cur.mem_read);
    assert property (@(negedge clk) ex_mem.mem_write === exp_cur.mem_write)
        else report_mismatch("ex_mem.mem_write", ex_mem.mem_write, exp_cur.mem_write);
    assert property (@(negedge clk) ex_mem.branch_taken === exp_cur.branch_taken)
        else report_mismatch("ex_mem.branch_taken", ex_mem.branch_taken, exp_cur.branch_taken);
    assert property (@(negedge clk) exp_cur.reg_write |-> ex_mem.rd === exp_cur.rd)
        else report_mismatch("ex_mem.rd", ex_mem.rd, exp_cur.rd);
    assert property (@(negedge clk)
        (exp_cur.reg_write || exp_cur.mem_write) |-> ex_mem.alu_data === exp_cur.alu_data)
        else report_mismatch("ex_mem.alu_data", ex_mem.alu_data, exp_cur.alu_data);
    assert property (@(negedge clk)
        exp_cur.mem_write |-> ex_mem.memory_data === exp_cur.memory_data)
        else report_mismatch("ex_mem.memory_data", ex_mem.memory_data, exp_cur.memory_data);
    assert property (@(negedge clk)
        exp_cur.branch_taken |-> ex_mem.branch_target === exp_cur.branch_target)
        else report_mismatch("ex_mem.branch_target", ex_mem.branch_target,
                             exp_cur.branch_target);

    initial begin
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        foreach (model_regs[i]) model_regs[i] = '0;
        wait (rst_n === 1'b1);
        for (int i = 0; i < PROG_LEN + DRAIN; i++) begin
            @(negedge clk);
            issue_next(i, i < PROG_LEN);
        end
        @(posedge clk);   // last negedge checks are done
        $display("issued %0d instructions, %0d flushed, %0d errors", issued, flushed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // reset, program and drain all fit well inside this window
    initial begin
        #((PROG_LEN + 20) * CLK_PERIOD);
        $display("watchdog expired, the program did not finish in time");
        $display("Testbench failed");
        $finish;
    end

endmodule

/* int_pipe.f */
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/id_ex_reg.sv
rtl/forward_unit.sv
rtl/alu.sv
rtl/execute_stage.sv
rtl/int_pipe_top.sv
dv/clk_gen.sv
dv/tb_int_pipe.sv

/* rtl/alu.sv */
module alu (
    input  isa_pkg::alu_op_e          alu_op,
    input  logic [isa_pkg::XLEN-1:0]  left_operand,
    input  logic [isa_pkg::XLEN-1:0]  right_operand,
    output logic [isa_pkg::XLEN-1:0]  result,
    output logic                      zero_flag
);

    logic less_signed;

    assign less_signed = $signed(left_operand) < $signed(right_operand);

    always_comb begin
        case (alu_op)
            isa_pkg::ALU_ADD: result = left_operand + right_operand;
            isa_pkg::ALU_SUB: result = left_operand - right_operand;
            isa_pkg::ALU_AND: result = left_operand & right_operand;
            isa_pkg::ALU_OR:  result = left_operand | right_operand;
            isa_pkg::ALU_XOR: result = left_operand ^ right_operand;
            isa_pkg::ALU_SLT: result = {{(isa_pkg::XLEN-1){1'b0}}, less_signed};
            default:          result = '0;
        endcase
    end

    assign zero_flag = (result == '0);   // BEQ uses this after SUB

endmodule

/* rtl/decode_stage.sv */
module decode_stage (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            instr_valid,
    input  logic [isa_pkg::XLEN-1:0]        instr,
    input  logic [isa_pkg::XLEN-1:0]        pc,
    input  logic                            wb_en,
    input  logic [isa_pkg::REG_ADDR_W-1:0]  wb_rd,
    input  logic [isa_pkg::XLEN-1:0]        wb_data,
    output pipe_pkg::id_ex_t                id_next
);

    isa_pkg::opcode_e                opcode;
    logic [2:0]                      funct3;
    logic                            funct7_alt;   // bit 30, selects SUB
    logic [isa_pkg::REG_ADDR_W-1:0]  rs1;
    logic [isa_pkg::REG_ADDR_W-1:0]  rs2;
    logic [isa_pkg::XLEN-1:0]        rs1_data;
    logic [isa_pkg::XLEN-1:0]        rs2_data;
    logic [isa_pkg::XLEN-1:0]        imm;
    pipe_pkg::control_t              ctrl;
    logic                            legal;

    assign opcode     = isa_pkg::opcode_e'(instr[6:0]);
    assign funct3     = instr[14:12];
    assign funct7_alt = instr[30];

    always_comb begin
        ctrl  = '0;
        legal = 1'b1;
        case (opcode)
            isa_pkg::OP: begin
                ctrl.encoding  = isa_pkg::R_TYPE;
                ctrl.reg_write = 1'b1;
                case (funct3)
                    isa_pkg::F3_ADD_SUB: begin
                        if (funct7_alt) ctrl.alu_op = isa_pkg::ALU_SUB;
                        else            ctrl.alu_op = isa_pkg::ALU_ADD;
                    end
                    isa_pkg::F3_SLT: ctrl.alu_op = isa_pkg::ALU_SLT;
                    isa_pkg::F3_XOR: ctrl.alu_op = isa_pkg::ALU_XOR;
                    isa_pkg::F3_OR:  ctrl.alu_op = isa_pkg::ALU_OR;
                    isa_pkg::F3_AND: ctrl.alu_op = isa_pkg::ALU_AND;
                    default:         legal = 1'b0;   // shifts and SLTU
                endcase
            end
            isa_pkg::OP_IMM: begin   // ADDI only
                ctrl.encoding  = isa_pkg::I_TYPE;
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                legal          = (funct3 == isa_pkg::F3_ADD_SUB);
            end
            isa_pkg::LOAD: begin
                ctrl.encoding  = isa_pkg::I_TYPE;
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                legal          = (funct3 == isa_pkg::F3_WORD);
            end
            isa_pkg::STORE: begin
                ctrl.encoding  = isa_pkg::S_TYPE;
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
                legal          = (funct3 == isa_pkg::F3_WORD);
            end
            isa_pkg::BRANCH: begin   // BEQ, compared by subtraction
                ctrl.encoding  = isa_pkg::B_TYPE;
                ctrl.alu_op    = isa_pkg::ALU_SUB;
                ctrl.is_branch = 1'b1;
                legal          = (funct3 == isa_pkg::F3_ADD_SUB);
            end
            isa_pkg::JAL: begin
                ctrl.encoding  = isa_pkg::J_TYPE;
                ctrl.is_jump   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            isa_pkg::JALR: begin
                ctrl.encoding  = isa_pkg::I_TYPE;
                ctrl.alu_src   = 1'b1;
                ctrl.is_jump   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            default: legal = 1'b0;
        endcase
    end

    always_comb begin
        case (ctrl.encoding)
            isa_pkg::I_TYPE: imm = {{20{instr[31]}}, instr[31:20]};
            isa_pkg::S_TYPE: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            isa_pkg::B_TYPE: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            isa_pkg::J_TYPE: imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default:         imm = '0;
        endcase
    end

    // only fields that really name a register reach the forwarding compare
    assign rs1 = (ctrl.encoding == isa_pkg::J_TYPE) ? '0 : instr[19:15];
    assign rs2 = (ctrl.encoding inside {isa_pkg::R_TYPE, isa_pkg::S_TYPE, isa_pkg::B_TYPE})
               ? instr[24:20] : '0;

    reg_file i_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1),
        .rs2_addr (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wb_en),
        .wr_addr  (wb_rd),
        .wr_data  (wb_data)
    );

    always_comb begin
        id_next.valid    = instr_valid && legal;
        id_next.control  = (instr_valid && legal) ? ctrl : '0;   // bubble carries no writes
        id_next.pc       = pc;
        id_next.rs1_data = rs1_data;
        id_next.rs2_data = rs2_data;
        id_next.imm      = imm;
        id_next.rs1      = rs1;
        id_next.rs2      = rs2;
        id_next.rd       = instr[11:7];
    end

endmodule

/* rtl/execute_stage.sv */
module execute_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  pipe_pkg::id_ex_t          id_cur,
    input  pipe_pkg::fwd_sel_e        forward_a,
    input  pipe_pkg::fwd_sel_e        forward_b,
    input  logic [isa_pkg::XLEN-1:0]  wb_data,
    output logic                      flush,
    output pipe_pkg::ex_mem_t         ex_mem
);

    logic [isa_pkg::XLEN-1:0] rs1_value;
    logic [isa_pkg::XLEN-1:0] rs2_value;
    logic [isa_pkg::XLEN-1:0] right_operand;
    logic [isa_pkg::XLEN-1:0] alu_result;
    logic                     zero_flag;
    logic                     taken;
    pipe_pkg::ex_mem_t        ex_next;

    function automatic logic [isa_pkg::XLEN-1:0] fwd_mux(
        input pipe_pkg::fwd_sel_e        sel,
        input logic [isa_pkg::XLEN-1:0]  reg_value,
        input logic [isa_pkg::XLEN-1:0]  ex_value,
        input logic [isa_pkg::XLEN-1:0]  wb_value
    );
        case (sel)
            pipe_pkg::FWD_FROM_EX: return ex_value;
            pipe_pkg::FWD_FROM_WB: return wb_value;
            default:               return reg_value;
        endcase
    endfunction

    assign rs1_value     = fwd_mux(forward_a, id_cur.rs1_data, ex_mem.alu_data, wb_data);
    assign rs2_value     = fwd_mux(forward_b, id_cur.rs2_data, ex_mem.alu_data, wb_data);
    assign right_operand = id_cur.control.alu_src ? id_cur.imm : rs2_value;

    alu i_alu (
        .alu_op        (id_cur.control.alu_op),
        .left_operand  (rs1_value),
        .right_operand (right_operand),
        .result        (alu_result),
        .zero_flag     (zero_flag)
    );

    assign taken = id_cur.valid && id_cur.control.is_branch && zero_flag;
    assign flush = taken;   // kills the instruction now in decode

    always_comb begin
        ex_next.valid         = id_cur.valid;
        ex_next.rd            = id_cur.rd;
        ex_next.reg_write     = id_cur.valid && id_cur.control.reg_write;
        ex_next.mem_read      = id_cur.valid && id_cur.control.mem_read;
        ex_next.mem_write     = id_cur.valid && id_cur.control.mem_write;
        ex_next.alu_data      = id_cur.control.is_jump ? id_cur.pc + 32'd4 : alu_result;
        ex_next.memory_data   = rs2_value;
        ex_next.branch_taken  = taken;
        ex_next.branch_target = id_cur.pc + id_cur.imm;
    end

    always_ff @(posedge clk) begin
        ex_mem <= ex_next;
        if (!rst_n) begin
            ex_mem.valid        <= 1'b0;
            ex_mem.reg_write    <= 1'b0;
            ex_mem.mem_read     <= 1'b0;
            ex_mem.mem_write    <= 1'b0;
            ex_mem.branch_taken <= 1'b0;
        end
    end

endmodule

/* rtl/forward_unit.sv */
module forward_unit (
    input  pipe_pkg::id_ex_t                id_cur,
    input  pipe_pkg::ex_mem_t               ex_mem,
    input  logic                            wb_en,
    input  logic [isa_pkg::REG_ADDR_W-1:0]  wb_rd,
    output pipe_pkg::fwd_sel_e              forward_a,
    output pipe_pkg::fwd_sel_e              forward_b
);

    // EX/MEM is younger than writeback, so it is checked first
    function automatic pipe_pkg::fwd_sel_e pick_source(
        input logic [isa_pkg::REG_ADDR_W-1:0] src,
        input pipe_pkg::ex_mem_t              ex,
        input logic                           wen,
        input logic [isa_pkg::REG_ADDR_W-1:0] wrd
    );
        if (src == '0) return pipe_pkg::FWD_NONE;   // x0 is always zero
        if (ex.valid && ex.reg_write && ex.rd == src) return pipe_pkg::FWD_FROM_EX;
        if (wen && wrd == src) return pipe_pkg::FWD_FROM_WB;
        return pipe_pkg::FWD_NONE;
    endfunction

    assign forward_a = pick_source(id_cur.rs1, ex_mem, wb_en, wb_rd);
    assign forward_b = pick_source(id_cur.rs2, ex_mem, wb_en, wb_rd);

endmodule

/* rtl/id_ex_reg.sv */
module id_ex_reg (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,     // taken BEQ in execute
    input  pipe_pkg::id_ex_t id_next,
    output pipe_pkg::id_ex_t id_cur
);

    always_ff @(posedge clk) begin
        id_cur <= id_next;
        // bubble: no valid, no control
        if (!rst_n || flush) begin
            id_cur.valid   <= 1'b0;
            id_cur.control <= '0;
        end
    end

endmodule

/* rtl/int_pipe_top.sv */
module int_pipe_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            instr_valid,
    input  logic [isa_pkg::XLEN-1:0]        instr,
    input  logic [isa_pkg::XLEN-1:0]        pc,
    input  logic                            wb_en,
    input  logic [isa_pkg::REG_ADDR_W-1:0]  wb_rd,
    input  logic [isa_pkg::XLEN-1:0]        wb_data,
    output pipe_pkg::ex_mem_t               ex_mem
);

    pipe_pkg::id_ex_t   id_next;     // decode output
    pipe_pkg::id_ex_t   id_cur;      // instruction in execute
    pipe_pkg::fwd_sel_e forward_a;
    pipe_pkg::fwd_sel_e forward_b;
    logic               flush;

    decode_stage i_decode_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .id_next     (id_next)
    );

    id_ex_reg i_id_ex_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush   (flush),
        .id_next (id_next),
        .id_cur  (id_cur)
    );

    forward_unit i_forward_unit (
        .id_cur    (id_cur),
        .ex_mem    (ex_mem),
        .wb_en     (wb_en),
        .wb_rd     (wb_rd),
        .forward_a (forward_a),
        .forward_b (forward_b)
    );

    execute_stage i_execute_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .id_cur    (id_cur),
        .forward_a (forward_a),
        .forward_b (forward_b),
        .wb_data   (wb_data),
        .flush     (flush),
        .ex_mem    (ex_mem)
    );

endmodule

/* rtl/isa_pkg.sv */
package isa_pkg;

    localparam int XLEN       = 32;                // data word width
    localparam int REG_ADDR_W = 5;                 // register index width
    localparam int REG_COUNT  = 1 << REG_ADDR_W;   // x0 included

    // major opcodes, bits [6:0] of the instruction word
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_e;

    // funct3 values used by the supported subset
    localparam logic [2:0] F3_ADD_SUB = 3'b000;    // also ADDI, BEQ
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_WORD    = 3'b010;    // LW / SW width
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    typedef enum logic [2:0] {R_TYPE, I_TYPE, S_TYPE, B_TYPE, J_TYPE} encoding_e;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT} alu_op_e;

endpackage

/* rtl/pipe_pkg.sv */
package pipe_pkg;

    // operand source chosen by the forwarding unit
    typedef enum logic [1:0] {
        FWD_NONE    = 2'b00,   // value read in decode
        FWD_FROM_EX = 2'b01,   // EX/MEM register
        FWD_FROM_WB = 2'b10    // writeback port
    } fwd_sel_e;

    typedef struct packed {
        isa_pkg::encoding_e encoding;
        isa_pkg::alu_op_e   alu_op;
        logic               alu_src;     // operand b is the immediate
        logic               is_branch;
        logic               is_jump;
        logic               reg_write;
        logic               mem_read;
        logic               mem_write;
    } control_t;

    typedef struct packed {
        logic                            valid;
        control_t                        control;
        logic [isa_pkg::XLEN-1:0]        pc;
        logic [isa_pkg::XLEN-1:0]        rs1_data;
        logic [isa_pkg::XLEN-1:0]        rs2_data;
        logic [isa_pkg::XLEN-1:0]        imm;
        logic [isa_pkg::REG_ADDR_W-1:0]  rs1;
        logic [isa_pkg::REG_ADDR_W-1:0]  rs2;
        logic [isa_pkg::REG_ADDR_W-1:0]  rd;
    } id_ex_t;

    typedef struct packed {
        logic                            valid;
        logic [isa_pkg::REG_ADDR_W-1:0]  rd;
        logic                            reg_write;
        logic                            mem_read;
        logic                            mem_write;
        logic [isa_pkg::XLEN-1:0]        alu_data;      // result, address or link value
        logic [isa_pkg::XLEN-1:0]        memory_data;   // store data
        logic                            branch_taken;
        logic [isa_pkg::XLEN-1:0]        branch_target;
    } ex_mem_t;

endpackage

/* rtl/reg_file.sv */
module reg_file (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [isa_pkg::REG_ADDR_W-1:0]  rs1_addr,
    input  logic [isa_pkg::REG_ADDR_W-1:0]  rs2_addr,
    output logic [isa_pkg::XLEN-1:0]        rs1_data,
    output logic [isa_pkg::XLEN-1:0]        rs2_data,
    input  logic                            wr_en,
    input  logic [isa_pkg::REG_ADDR_W-1:0]  wr_addr,
    input  logic [isa_pkg::XLEN-1:0]        wr_data
);

    logic [isa_pkg::XLEN-1:0] regs [1:isa_pkg::REG_COUNT-1];   // no storage for x0

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < isa_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // x0 reads zero, a same-cycle write is passed straight through
    assign rs1_data = (rs1_addr == '0)                  ? '0      :
                      (wr_en && wr_addr == rs1_addr)    ? wr_data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0)                  ? '0      :
                      (wr_en && wr_addr == rs2_addr)    ? wr_data : regs[rs2_addr];

endmodule
